/* rtl/mini_core_pkg.sv */
`default_nettype none

package mini_core_pkg;

    localparam int xlen = 32;

    typedef logic [4:0] reg_addr_t;

    // Major opcodes of the supported groups
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_lui    = 7'b0110111;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    ////////////////////
    // Instruction formats
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        u_type_t u;
    } instr_u;

    ////////////////////
    // Stage packets
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        instr_u          instr;
    } fetch_packet_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        instr_u          instr;
        alu_op_e         alu_op;
        logic [xlen-1:0] operand_a;
        logic [xlen-1:0] operand_b;
        reg_addr_t       rd;
        logic            wr_en;
    } issue_packet_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        instr_u          instr;
        reg_addr_t       rd;
        logic            wr_en;
        logic [xlen-1:0] value;
    } retire_t;

    typedef struct packed {
        logic            valid;
        logic            wr_en;
        reg_addr_t       rd;
        logic [xlen-1:0] value;
    } fwd_t;

endpackage

`default_nettype wire

/* rtl/fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch
    import mini_core_pkg::*;
#(
    parameter logic [xlen-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            arst_n,
    output logic            imem_req,
    output logic [xlen-1:0] imem_addr,
    input  logic            imem_rvalid,
    input  logic [xlen-1:0] imem_rdata,
    output fetch_packet_t   fetch
);

    logic [xlen-1:0] pc;
    logic            req_pending;
    logic            done;
    logic            pkt_valid;
    logic [xlen-1:0] pkt_pc;
    instr_u          pkt_instr;

    // Request completes in the cycle the word comes back
    assign done      = req_pending & imem_rvalid;
    assign imem_req  = req_pending;
    assign imem_addr = pc;

    // Request is idle for one cycle after each completion
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc          <= RESET_PC;
            req_pending <= 1'b0;
            pkt_valid   <= 1'b0;
        end else begin
            pkt_valid <= done;
            if (done) begin
                pc          <= pc + xlen'(4);
                req_pending <= 1'b0;
            end else if (!req_pending) begin
                req_pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            pkt_pc    <= pc;
            pkt_instr <= imem_rdata;
        end
    end

    assign fetch = '{valid: pkt_valid, pc: pkt_pc, instr: pkt_instr};

endmodule

`default_nettype wire

/* rtl/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file
    import mini_core_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  reg_addr_t       rs1_addr,
    input  reg_addr_t       rs2_addr,
    output logic [xlen-1:0] rs1_data,
    output logic [xlen-1:0] rs2_data,
    input  logic            wr_en,
    input  reg_addr_t       wr_addr,
    input  logic [xlen-1:0] wr_data
);

    // x0 has no storage
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 1; k < 32; k++)
                regs[k] <= '0;
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Reads see the old value during a write
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* rtl/decode_and_issue.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_and_issue
    import mini_core_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  fetch_packet_t   fetch,
    output reg_addr_t       rs1_addr,
    output reg_addr_t       rs2_addr,
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,
    input  fwd_t            alu_fwd,
    input  fwd_t            wb_fwd,
    output issue_packet_t   issue
);

    instr_u          instr;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] op_b;
    alu_op_e         op;
    logic            supported;
    issue_packet_t   next;
    issue_packet_t   issue_q;
    logic            issue_valid;

    // Youngest matching writer wins and x0 never forwards
    function automatic logic [xlen-1:0] resolve(
        input reg_addr_t       addr,
        input logic [xlen-1:0] rf_val,
        input fwd_t            young,
        input fwd_t            old
    );
        logic [xlen-1:0] val;
        val = rf_val;
        if (addr != '0) begin
            if (young.valid && young.wr_en && young.rd == addr)
                val = young.value;
            else if (old.valid && old.wr_en && old.rd == addr)
                val = old.value;
        end
        return val;
    endfunction

    ////////////////////
    // Field decode
    assign instr    = fetch.instr;
    assign rs1_addr = instr.r.rs1;
    assign rs2_addr = instr.r.rs2;
    assign imm_i    = {{(xlen-12){instr.i.imm[11]}}, instr.i.imm};
    assign imm_u    = {instr.u.imm, 12'b0};

    always_comb begin
        op        = alu_add;
        supported = 1'b1;
        case (instr.r.opcode)
            opcode_op, opcode_op_imm: begin
                case (instr.r.funct3)
                    // Only the register form has sub
                    3'b000:  op = (instr.r.opcode == opcode_op && instr.r.funct7[5])
                                  ? alu_sub : alu_add;
                    3'b001:  op = alu_sll;
                    3'b010:  op = alu_slt;
                    3'b011:  op = alu_sltu;
                    3'b100:  op = alu_xor;
                    3'b101:  op = instr.r.funct7[5] ? alu_sra : alu_srl;
                    3'b110:  op = alu_or;
                    default: op = alu_and;
                endcase
            end
            opcode_lui: op = alu_pass_b;
            default:    supported = 1'b0;
        endcase
    end

    ////////////////////
    // Operands
    assign rs1_val = resolve(rs1_addr, rs1_data, alu_fwd, wb_fwd);
    assign rs2_val = resolve(rs2_addr, rs2_data, alu_fwd, wb_fwd);

    always_comb begin
        case (instr.r.opcode)
            opcode_op:  op_b = rs2_val;
            opcode_lui: op_b = imm_u;
            default:    op_b = imm_i;
        endcase
    end

    always_comb begin
        next           = '0;
        next.valid     = fetch.valid;
        next.pc        = fetch.pc;
        next.instr     = instr;
        next.alu_op    = op;
        next.operand_a = rs1_val;
        next.operand_b = op_b;
        next.rd        = instr.r.rd;
        next.wr_en     = supported && (instr.r.rd != '0);
    end

    ////////////////////
    // Issue register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            issue_valid <= 1'b0;
        else
            issue_valid <= next.valid;
    end

    always_ff @(posedge clk) begin
        issue_q <= next;
    end

    always_comb begin
        issue       = issue_q;
        issue.valid = issue_valid;
    end

endmodule

`default_nettype wire

/* rtl/alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit
    import mini_core_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n,
    input  issue_packet_t issue,
    output retire_t       result,
    output fwd_t          fwd
);

    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [4:0]      shamt;
    logic [xlen-1:0] y;
    retire_t         next;
    retire_t         result_q;
    logic            result_valid;

    assign a     = issue.operand_a;
    assign b     = issue.operand_b;
    assign shamt = b[4:0];

    always_comb begin
        case (issue.alu_op)
            alu_add:  y = a + b;
            alu_sub:  y = a - b;
            alu_sll:  y = a << shamt;
            alu_slt:  y = xlen'($signed(a) < $signed(b));
            alu_sltu: y = xlen'(a < b);
            alu_xor:  y = a ^ b;
            alu_srl:  y = a >> shamt;
            alu_sra:  y = $unsigned($signed(a) >>> shamt);
            alu_or:   y = a | b;
            alu_and:  y = a & b;
            default:  y = b;
        endcase
    end

    always_comb begin
        next       = '0;
        next.valid = issue.valid;
        next.pc    = issue.pc;
        next.instr = issue.instr;
        next.rd    = issue.rd;
        next.wr_en = issue.wr_en;
        next.value = y;
    end

    ////////////////////
    // Result register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            result_valid <= 1'b0;
        else
            result_valid <= next.valid;
    end

    always_ff @(posedge clk) begin
        result_q <= next;
    end

    always_comb begin
        result       = result_q;
        result.valid = result_valid;
    end

    // Youngest forwarding source
    assign fwd = '{valid: result.valid, wr_en: result.wr_en, rd: result.rd,
                   value: result.value};

endmodule

`default_nettype wire

/* rtl/write_back.sv */
`timescale 1ns/1ps
`default_nettype none

module write_back
    import mini_core_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  retire_t         result,
    output logic            wr_en,
    output reg_addr_t       wr_addr,
    output logic [xlen-1:0] wr_data,
    output fwd_t            fwd,
    output retire_t         trace
);

    retire_t wb_q;
    logic    wb_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            wb_valid <= 1'b0;
        else
            wb_valid <= result.valid;
    end

    always_ff @(posedge clk) begin
        wb_q <= result;
    end

    always_comb begin
        trace       = wb_q;
        trace.valid = wb_valid;
    end

    // Register file is written from the retiring entry
    assign wr_en   = trace.valid & trace.wr_en;
    assign wr_addr = trace.rd;
    assign wr_data = trace.value;

    assign fwd = '{valid: trace.valid, wr_en: trace.wr_en, rd: trace.rd,
                   value: trace.value};

endmodule

`default_nettype wire

/* rtl/mini_core.sv */
`timescale 1ns/1ps
`default_nettype none

module mini_core
    import mini_core_pkg::*;
#(
    parameter logic [xlen-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            arst_n,
    output logic            imem_req,
    output logic [xlen-1:0] imem_addr,
    input  logic            imem_rvalid,
    input  logic [xlen-1:0] imem_rdata,
    output retire_t         trace
);

    fetch_packet_t   fetch_pkt;
    issue_packet_t   issue_pkt;
    retire_t         alu_result;
    fwd_t            alu_fwd;
    fwd_t            wb_fwd;
    reg_addr_t       rs1_addr;
    reg_addr_t       rs2_addr;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic            rf_wr_en;
    reg_addr_t       rf_wr_addr;
    logic [xlen-1:0] rf_wr_data;

    ////////////////////
    // Fetch
    fetch #(.RESET_PC(RESET_PC)) fetch_block (
        .clk(clk), .arst_n(arst_n),
        .imem_req(imem_req), .imem_addr(imem_addr),
        .imem_rvalid(imem_rvalid), .imem_rdata(imem_rdata),
        .fetch(fetch_pkt)
    );

    ////////////////////
    // Decode and issue
    decode_and_issue decode_and_issue_block (
        .clk(clk), .arst_n(arst_n), .fetch(fetch_pkt),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .alu_fwd(alu_fwd), .wb_fwd(wb_fwd), .issue(issue_pkt)
    );

    register_file register_file_block (
        .clk(clk), .arst_n(arst_n),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wr_en(rf_wr_en), .wr_addr(rf_wr_addr), .wr_data(rf_wr_data)
    );

    ////////////////////
    // Execute and writeback
    alu_unit alu_unit_block (
        .clk(clk), .arst_n(arst_n), .issue(issue_pkt),
        .result(alu_result), .fwd(alu_fwd)
    );

    write_back write_back_block (
        .clk(clk), .arst_n(arst_n), .result(alu_result),
        .wr_en(rf_wr_en), .wr_addr(rf_wr_addr), .wr_data(rf_wr_data),
        .fwd(wb_fwd), .trace(trace)
    );

endmodule

`default_nettype wire

/* sim/core_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module core_checker
    import mini_core_pkg::*;
#(
    parameter logic [xlen-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            imem_req,
    input  logic [xlen-1:0] imem_addr,
    input  logic            imem_rvalid,
    input  logic [xlen-1:0] imem_rdata,
    input  retire_t         trace,
    output int              retire_count,
    output int              error_count,
    output int              fwd_error_count
);

    typedef struct packed {
        logic [31:0] cycle;
        logic [31:0] pc;
        logic [31:0] word;
    } fetched_t;

    fetched_t        in_flight [$];
    logic [31:0]     model_regs [0:31];
    logic [xlen-1:0] next_fetch_pc;
    logic [31:0]     cycle_count;
    logic [4:0]      prev_rd [0:1];
    logic            prev_we [0:1];

    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERROR %s: expected %h, actual %h", test, expected, actual);
        error_count++;
    endtask

    // RV32I semantics on the model registers
    task automatic model_execute(input logic [31:0] word, output logic we,
                                 output logic [31:0] value, output logic uses_rs1,
                                 output logic uses_rs2);
        logic [31:0] a;
        logic [31:0] b;
        logic        alt;
        a        = model_regs[word[19:15]];
        b        = (word[6:0] == opcode_op) ? model_regs[word[24:20]]
                                            : {{20{word[31]}}, word[31:20]};
        alt      = word[30];
        uses_rs1 = (word[6:0] == opcode_op) || (word[6:0] == opcode_op_imm);
        uses_rs2 = (word[6:0] == opcode_op);
        we       = (uses_rs1 || word[6:0] == opcode_lui) && word[11:7] != 5'd0;
        if (word[6:0] == opcode_lui) begin
            value = {word[31:12], 12'h000};
        end else begin
            case (word[14:12])
                3'd0:    value = (uses_rs2 && alt) ? a - b : a + b;
                3'd1:    value = a << b[4:0];
                3'd2:    value = {31'b0, $signed(a) < $signed(b)};
                3'd3:    value = {31'b0, a < b};
                3'd4:    value = a ^ b;
                3'd5:    value = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
                3'd6:    value = a | b;
                default: value = a & b;
            endcase
        end
    endtask

    task automatic check_retire(input fetched_t f);
        logic        exp_we;
        logic [31:0] exp_value;
        logic        uses_rs1;
        logic        uses_rs2;
        logic        dependent;
        model_execute(f.word, exp_we, exp_value, uses_rs1, uses_rs2);
        if (trace.pc != f.pc)
            report_mismatch("retire_order", f.pc, trace.pc);
        if (trace.instr != f.word)
            report_mismatch("retire_instr", f.word, trace.instr);
        if (cycle_count - f.cycle != 32'd4)
            report_mismatch("retire_latency", 32'd4, cycle_count - f.cycle);
        if (trace.wr_en != exp_we)
            report_mismatch("write_enable", {31'b0, exp_we}, {31'b0, trace.wr_en});

        // Source written by one of the two previous instructions
        dependent = 1'b0;
        for (int k = 0; k < 2; k++) begin
            if (prev_we[k] && uses_rs1 && f.word[19:15] == prev_rd[k])
                dependent = 1'b1;
            if (prev_we[k] && uses_rs2 && f.word[24:20] == prev_rd[k])
                dependent = 1'b1;
        end

        if (exp_we) begin
            if (trace.rd != f.word[11:7])
                report_mismatch("dest_reg", {27'b0, f.word[11:7]}, {27'b0, trace.rd});
            if (trace.value != exp_value) begin
                if (dependent) begin
                    report_mismatch("alu_forwarded", exp_value, trace.value);
                    fwd_error_count++;
                end else begin
                    report_mismatch("alu_result", exp_value, trace.value);
                end
            end
            model_regs[f.word[11:7]] = exp_value;
        end
        prev_rd[1] = prev_rd[0];
        prev_we[1] = prev_we[0];
        prev_rd[0] = f.word[11:7];
        prev_we[0] = exp_we;
    endtask

    ////////////////////
    // Sampled on the rising edge while inputs move on the falling one
    always @(posedge clk) begin
        fetched_t f;
        if (!arst_n) begin
            in_flight.delete();
            next_fetch_pc = RESET_PC;
            cycle_count   = '0;
            for (int k = 0; k < 32; k++)
                model_regs[k] = '0;
            prev_we[0] = 1'b0;
            prev_we[1] = 1'b0;
            prev_rd[0] = '0;
            prev_rd[1] = '0;
        end else begin
            cycle_count = cycle_count + 32'd1;
            if (cycle_count == 32'd1 && imem_req) begin
                $display("Fetch request raised in the first cycle after reset");
                error_count++;
            end
            if (imem_req && imem_addr != next_fetch_pc)
                report_mismatch("fetch_address", next_fetch_pc, imem_addr);
            if (imem_req && imem_rvalid) begin
                f.cycle = cycle_count;
                f.pc    = next_fetch_pc;
                f.word  = imem_rdata;
                in_flight.push_back(f);
                next_fetch_pc = next_fetch_pc + 32'd4;
            end

            if (trace.valid) begin
                if (in_flight.size() == 0) begin
                    $display("Instruction retired at pc %h with nothing fetched", trace.pc);
                    error_count++;
                end else begin
                    f = in_flight.pop_front();
                    retire_count++;
                    check_retire(f);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* sim/tb_mini_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mini_core
    import mini_core_pkg::*;
#(
    parameter logic [xlen-1:0] RESET_PC = 32'h0000_0200
) ();

    localparam int num_instrs     = 256;
    localparam int timeout_cycles = num_instrs * 6 + 50;

    logic            clk;
    logic            arst_n = 1'b0;
    logic            imem_req;
    logic [xlen-1:0] imem_addr;
    logic            imem_rvalid = 1'b0;
    logic [xlen-1:0] imem_rdata = '0;
    retire_t         trace;

    logic [31:0]     program_mem [0:255];
    logic            mem_busy = 1'b0;
    int              wait_left = 0;
    int              retire_count;
    int              error_count;
    int              fwd_error_count;
    int              cycles;
    logic            timed_out;

    mini_core #(.RESET_PC(RESET_PC)) i_dut (
        .clk(clk), .arst_n(arst_n),
        .imem_req(imem_req), .imem_addr(imem_addr),
        .imem_rvalid(imem_rvalid), .imem_rdata(imem_rdata),
        .trace(trace)
    );

    core_checker #(.RESET_PC(RESET_PC)) core_checker (
        .clk(clk), .arst_n(arst_n),
        .imem_req(imem_req), .imem_addr(imem_addr),
        .imem_rvalid(imem_rvalid), .imem_rdata(imem_rdata),
        .trace(trace),
        .retire_count(retire_count), .error_count(error_count),
        .fwd_error_count(fwd_error_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////
    // Random program over registers x0 to x7
    function automatic logic [31:0] random_instr();
        int unsigned kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [6:0]  opcode;
        kind = $urandom_range(0, 9);
        rd   = 5'($urandom_range(0, 7));
        rs1  = 5'($urandom_range(0, 7));
        rs2  = 5'($urandom_range(0, 7));
        f3   = 3'($urandom_range(0, 7));
        imm  = 12'($urandom());
        f7   = 7'h00;
        // Only add/sub and the right shifts have an alternate funct7
        if ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1) == 1)
            f7 = 7'h20;
        if (kind == 0) begin
            // Load, store, branch and JAL are all unsupported
            case ($urandom_range(0, 3))
                0:       opcode = 7'b0000011;
                1:       opcode = 7'b0100011;
                2:       opcode = 7'b1100011;
                default: opcode = 7'b1101111;
            endcase
            return {f7, rs2, rs1, f3, rd, opcode};
        end else if (kind <= 4) begin
            return {f7, rs2, rs1, f3, rd, opcode_op};
        end else if (kind <= 8) begin
            // Shift immediates carry funct7 in the upper bits
            if (f3 == 3'd1 || f3 == 3'd5)
                imm = {f7, imm[4:0]};
            return {imm, rs1, f3, rd, opcode_op_imm};
        end
        return {20'($urandom()), rd, opcode_lui};
    endfunction

    ////////////////////
    // Instruction memory with 0 to 3 wait cycles per request
    always @(negedge clk) begin
        if (!arst_n) begin
            imem_rvalid = 1'b0;
            mem_busy    = 1'b0;
        end else if (imem_rvalid) begin
            imem_rvalid = 1'b0;
            mem_busy    = 1'b0;
        end else if (imem_req) begin
            if (!mem_busy) begin
                mem_busy  = 1'b1;
                wait_left = $urandom_range(0, 3);
            end
            if (wait_left == 0) begin
                imem_rvalid = 1'b1;
                imem_rdata  = program_mem[imem_addr[9:2]];
            end else begin
                wait_left--;
            end
        end
    end

    initial begin
        void'($urandom(83));
        timed_out = 1'b0;
        for (int k = 0; k < 256; k++)
            program_mem[k] = random_instr();
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        cycles = 0;
        while (retire_count < num_instrs && !timed_out) begin
            @(negedge clk);
            cycles++;
            if (cycles >= timeout_cycles)
                timed_out = 1'b1;
        end

        $display("Retired %0d, errors %0d, forwarding errors %0d",
                 retire_count, error_count, fwd_error_count);
        if (timed_out)
            $display("Timeout: only %0d of %0d instructions retired in %0d cycles",
                     retire_count, num_instrs, cycles);
        if (timed_out || error_count != 0)
            $display("STATUS: FAIL");
        else
            $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
rtl/mini_core_pkg.sv
rtl/fetch.sv
rtl/register_file.sv
rtl/decode_and_issue.sv
rtl/alu_unit.sv
rtl/write_back.sv
rtl/mini_core.sv
sim/core_checker.sv
sim/tb_mini_core.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the mini_core testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_mini_core -f tb.f -o tb_mini_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_mini_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
    exit 0
fi
exit 1
